/* hdl/dlx_pkg.sv */
package dlx_pkg;

    //////////////////////////////
    // widths and fixed values
    //////////////////////////////

    localparam int word_w    = 32;
    localparam int reg_idx_w = 5;

    localparam logic [word_w-1:0]    pc_step  = word_w'(4);
    localparam logic [word_w-1:0]    reset_pc = '0;
    localparam logic [reg_idx_w-1:0] reg_zero = '0;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // primary opcode, 0 with func 0 is the nop
    typedef enum logic [5:0] {
        op_alu_r = 6'h00,
        op_j     = 6'h02,
        op_beqz  = 6'h04,
        op_bnez  = 6'h05,
        op_addi  = 6'h08,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_lhi   = 6'h0f,
        op_jr    = 6'h12,
        op_slli  = 6'h14,
        op_lb    = 6'h20,
        op_lh    = 6'h21,
        op_lw    = 6'h23,
        op_lbu   = 6'h24,
        op_lhu   = 6'h25,
        op_sb    = 6'h28,
        op_sh    = 6'h29,
        op_sw    = 6'h2b
    } opcode_t;

    // r-type function field
    typedef enum logic [5:0] {
        fn_nop = 6'h00,
        fn_sll = 6'h04,
        fn_srl = 6'h06,
        fn_sra = 6'h07,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_xor = 6'h26,
        fn_seq = 6'h28,
        fn_sne = 6'h29,
        fn_slt = 6'h2a
    } func_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll,
        alu_srl, alu_sra, alu_slt, alu_seq, alu_sne, alu_lhi
    } alu_op_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } dsize_t;

    //////////////////////////////
    // instruction word views
    //////////////////////////////

    typedef struct packed {
        opcode_t              opcode;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rd;
        logic [4:0]           shamt;
        func_t                func;
    } r_view_t;

    // j-type imm26 is the low 26 bits of this view
    typedef struct packed {
        opcode_t              opcode;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rd;
        logic [15:0]          imm16;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

endpackage

/* hdl/fetch_unit.sv */
module fetch_unit
    import dlx_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              leap,
    input  logic [word_w-1:0] leap_addr,
    output logic [word_w-1:0] imem_addr,
    input  logic [word_w-1:0] imem_data,
    output logic [word_w-1:0] if_pc_next,
    output instr_u            if_instr
);

    logic [word_w-1:0] pc;
    logic [word_w-1:0] pc_plus4;

    // instruction memory answers in the same cycle
    assign imem_addr = pc;
    assign pc_plus4  = pc + pc_step;

    // pc and instruction half of if/id
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            // nop into decode
            if_instr <= '0;
        end else begin
            // leap comes from ex/mem, so three slots already fetched
            pc       <= leap ? leap_addr : pc_plus4;
            if_instr <= imem_data;
        end
    end

    // return address half of if/id
    always_ff @(posedge clk) begin
        if_pc_next <= pc_plus4;
    end

endmodule

/* hdl/register_file.sv */
module register_file
    import dlx_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [reg_idx_w-1:0] rs1_idx,
    input  logic [reg_idx_w-1:0] rs2_idx,
    output logic [word_w-1:0]    rs1_value,
    output logic [word_w-1:0]    rs2_value,
    input  logic                 wb_we,
    input  logic [reg_idx_w-1:0] wb_rd,
    input  logic [word_w-1:0]    wb_value
);

    logic [word_w-1:0] regs [2**reg_idx_w];

    // one write port, r0 never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_idx_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && (wb_rd != reg_zero)) begin
            regs[wb_rd] <= wb_value;
        end
    end

    // no write-through, value visible the cycle after the edge
    assign rs1_value = regs[rs1_idx];
    assign rs2_value = regs[rs2_idx];

endmodule

/* hdl/decode_control.sv */
module decode_control
    import dlx_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [word_w-1:0]    if_pc_next,
    input  instr_u               if_instr,
    input  logic [word_w-1:0]    rs1_value,
    input  logic [word_w-1:0]    rs2_value,
    output logic [reg_idx_w-1:0] rs1_idx,
    output logic [reg_idx_w-1:0] rs2_idx,
    output logic [word_w-1:0]    ex_pc_next,
    output logic [word_w-1:0]    ex_op_a,
    output logic [word_w-1:0]    ex_op_b,
    output logic [word_w-1:0]    ex_imm,
    output logic [reg_idx_w-1:0] ex_dest,
    output alu_op_t              ex_alu_op,
    output logic                 ex_use_imm,
    output logic                 ex_branch,
    output logic                 ex_branch_zero,
    output logic                 ex_jump,
    output logic                 ex_reg_to_pc,
    output logic                 ex_reg_write,
    output logic                 ex_mem_to_reg,
    output logic                 ex_mem_write,
    output logic                 ex_load_sign,
    output dsize_t               ex_dsize
);

    opcode_t              op;
    logic [reg_idx_w-1:0] dest;
    logic [word_w-1:0]    imm;
    alu_op_t              alu_op;
    logic                 use_imm;
    logic                 branch;
    logic                 branch_zero;
    logic                 jump;
    logic                 reg_to_pc;
    logic                 reg_write;
    logic                 mem_to_reg;
    logic                 mem_write;
    logic                 load_sign;
    dsize_t               dsize;

    assign op = if_instr.i.opcode;

    // store data sits in the rs2 slot, read through port 2
    assign rs1_idx = if_instr.r.rs1;
    assign rs2_idx = if_instr.r.rs2;

    //////////////////////////////
    // opcode decode
    //////////////////////////////

    always_comb begin
        dest        = if_instr.i.rd;
        imm         = {{16{if_instr.i.imm16[15]}}, if_instr.i.imm16};
        alu_op      = alu_add;
        use_imm     = 1'b0;
        branch      = 1'b0;
        branch_zero = 1'b0;
        jump        = 1'b0;
        reg_to_pc   = 1'b0;
        reg_write   = 1'b0;
        mem_to_reg  = 1'b0;
        mem_write   = 1'b0;
        load_sign   = (op != op_lbu) && (op != op_lhu);
        // access size for loads and stores
        case (op)
            op_lb, op_lbu, op_sb: dsize = size_byte;
            op_lh, op_lhu, op_sh: dsize = size_half;
            default:              dsize = size_word;
        endcase
        case (op)
            op_alu_r: begin
                dest      = if_instr.r.rd;
                reg_write = 1'b1;
                case (if_instr.r.func)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_sra:  alu_op = alu_sra;
                    fn_slt:  alu_op = alu_slt;
                    fn_seq:  alu_op = alu_seq;
                    fn_sne:  alu_op = alu_sne;
                    // nop and unknown func write nothing
                    default: reg_write = 1'b0;
                endcase
            end
            op_addi, op_slli, op_lhi, op_andi, op_ori, op_xori: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                case (op)
                    op_slli: alu_op = alu_sll;
                    op_lhi:  alu_op = alu_lhi;
                    op_andi: alu_op = alu_and;
                    op_ori:  alu_op = alu_or;
                    op_xori: alu_op = alu_xor;
                    default: alu_op = alu_add;
                endcase
                // logical immediates are zero extended
                if (op inside {op_andi, op_ori, op_xori}) begin
                    imm = {16'b0, if_instr.i.imm16};
                end
            end
            op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
                use_imm    = 1'b1;
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
            end
            op_sb, op_sh, op_sw: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            op_beqz: begin
                branch      = 1'b1;
                branch_zero = 1'b1;
            end
            op_bnez: branch = 1'b1;
            op_j: begin
                jump = 1'b1;
                imm  = {{6{if_instr.i.rs1[4]}}, if_instr.i.rs1, if_instr.i.rd,
                        if_instr.i.imm16};
            end
            op_jr:   reg_to_pc = 1'b1;
            default: reg_write = 1'b0;
        endcase
    end

    //////////////////////////////
    // id/ex register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_alu_op      <= alu_add;
            ex_use_imm     <= 1'b0;
            ex_branch      <= 1'b0;
            ex_branch_zero <= 1'b0;
            ex_jump        <= 1'b0;
            ex_reg_to_pc   <= 1'b0;
            ex_reg_write   <= 1'b0;
            ex_mem_to_reg  <= 1'b0;
            ex_mem_write   <= 1'b0;
            ex_load_sign   <= 1'b0;
            ex_dsize       <= size_byte;
        end else begin
            ex_alu_op      <= alu_op;
            ex_use_imm     <= use_imm;
            ex_branch      <= branch;
            ex_branch_zero <= branch_zero;
            ex_jump        <= jump;
            ex_reg_to_pc   <= reg_to_pc;
            ex_reg_write   <= reg_write;
            ex_mem_to_reg  <= mem_to_reg;
            ex_mem_write   <= mem_write;
            ex_load_sign   <= load_sign;
            ex_dsize       <= dsize;
        end
    end

    // operands and addresses
    always_ff @(posedge clk) begin
        ex_pc_next <= if_pc_next;
        ex_op_a    <= rs1_value;
        ex_op_b    <= rs2_value;
        ex_imm     <= imm;
        ex_dest    <= dest;
    end

endmodule

/* hdl/execute_unit.sv */
module execute_unit
    import dlx_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [word_w-1:0]    ex_pc_next,
    input  logic [word_w-1:0]    ex_op_a,
    input  logic [word_w-1:0]    ex_op_b,
    input  logic [word_w-1:0]    ex_imm,
    input  logic [reg_idx_w-1:0] ex_dest,
    input  alu_op_t              ex_alu_op,
    input  logic                 ex_use_imm,
    input  logic                 ex_branch,
    input  logic                 ex_branch_zero,
    input  logic                 ex_jump,
    input  logic                 ex_reg_to_pc,
    input  logic                 ex_reg_write,
    input  logic                 ex_mem_to_reg,
    input  logic                 ex_mem_write,
    input  logic                 ex_load_sign,
    input  dsize_t               ex_dsize,
    output logic [word_w-1:0]    mem_alu_result,
    output logic [word_w-1:0]    mem_store_data,
    output logic [reg_idx_w-1:0] mem_dest,
    output logic                 mem_reg_write,
    output logic                 mem_mem_to_reg,
    output logic                 mem_mem_write,
    output logic                 mem_load_sign,
    output dsize_t               mem_dsize,
    output logic                 leap,
    output logic [word_w-1:0]    leap_addr
);

    logic [word_w-1:0] op_b_sel;
    logic [word_w-1:0] alu_result;
    logic [4:0]        shamt;
    logic              taken;

    assign op_b_sel = ex_use_imm ? ex_imm : ex_op_b;
    assign shamt    = op_b_sel[4:0];

    //////////////////////////////
    // alu
    //////////////////////////////

    always_comb begin
        case (ex_alu_op)
            alu_add: alu_result = ex_op_a + op_b_sel;
            alu_sub: alu_result = ex_op_a - op_b_sel;
            alu_and: alu_result = ex_op_a & op_b_sel;
            alu_or:  alu_result = ex_op_a | op_b_sel;
            alu_xor: alu_result = ex_op_a ^ op_b_sel;
            alu_sll: alu_result = ex_op_a << shamt;
            alu_srl: alu_result = ex_op_a >> shamt;
            alu_sra: alu_result = $signed(ex_op_a) >>> shamt;
            alu_slt: alu_result = word_w'($signed(ex_op_a) < $signed(op_b_sel));
            alu_seq: alu_result = word_w'(ex_op_a == op_b_sel);
            alu_sne: alu_result = word_w'(ex_op_a != op_b_sel);
            // imm16 into the upper half
            alu_lhi: alu_result = {op_b_sel[15:0], 16'b0};
            default: alu_result = '0;
        endcase
    end

    // beqz when op_a is zero, bnez otherwise
    assign taken = ex_branch && ((ex_op_a == '0) == ex_branch_zero);

    //////////////////////////////
    // ex/mem register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_reg_write  <= 1'b0;
            mem_mem_to_reg <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_load_sign  <= 1'b0;
            mem_dsize      <= size_byte;
            leap           <= 1'b0;
        end else begin
            mem_reg_write  <= ex_reg_write;
            mem_mem_to_reg <= ex_mem_to_reg;
            mem_mem_write  <= ex_mem_write;
            mem_load_sign  <= ex_load_sign;
            mem_dsize      <= ex_dsize;
            leap           <= taken || ex_jump || ex_reg_to_pc;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result <= alu_result;
        mem_store_data <= ex_op_b;
        mem_dest       <= ex_dest;
        // jr target or pc relative
        leap_addr      <= ex_reg_to_pc ? ex_op_a : ex_pc_next + ex_imm;
    end

endmodule

/* hdl/memory_writeback.sv */
module memory_writeback
    import dlx_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [word_w-1:0]    mem_alu_result,
    input  logic [word_w-1:0]    mem_store_data,
    input  logic [reg_idx_w-1:0] mem_dest,
    input  logic                 mem_reg_write,
    input  logic                 mem_mem_to_reg,
    input  logic                 mem_mem_write,
    input  logic                 mem_load_sign,
    input  dsize_t               mem_dsize,
    input  logic [word_w-1:0]    dmem_rdata,
    output logic [word_w-1:0]    dmem_addr,
    output logic [word_w-1:0]    dmem_wdata,
    output dsize_t               dmem_size,
    output logic                 dmem_we,
    output logic                 wb_we,
    output logic [reg_idx_w-1:0] wb_rd,
    output logic [word_w-1:0]    wb_value
);

    logic [7:0]        byte_lane;
    logic [15:0]       half_lane;
    logic [word_w-1:0] load_value;
    logic [word_w-1:0] wb_alu;
    logic [word_w-1:0] wb_load;
    logic              wb_mem_to_reg;

    // memory does the lane steering for stores
    assign dmem_addr  = mem_alu_result;
    assign dmem_wdata = mem_store_data;
    assign dmem_size  = mem_dsize;
    assign dmem_we    = mem_mem_write;

    //////////////////////////////
    // load lanes
    //////////////////////////////

    // big-endian so address 0 is the top lane
    assign byte_lane = dmem_rdata[{~mem_alu_result[1:0], 3'b000} +: 8];
    assign half_lane = dmem_rdata[{~mem_alu_result[1], 4'b0000} +: 16];

    always_comb begin
        case (mem_dsize)
            size_byte: load_value = {{24{mem_load_sign & byte_lane[7]}}, byte_lane};
            size_half: load_value = {{16{mem_load_sign & half_lane[15]}}, half_lane};
            default:   load_value = dmem_rdata;
        endcase
    end

    //////////////////////////////
    // mem/wb register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we         <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end else begin
            wb_we         <= mem_reg_write;
            wb_mem_to_reg <= mem_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_dest;
        wb_alu  <= mem_alu_result;
        wb_load <= load_value;
    end

    // write-back select
    assign wb_value = wb_mem_to_reg ? wb_load : wb_alu;

endmodule

/* hdl/dlx_core.sv */
module dlx_core
    import dlx_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    output logic [word_w-1:0] imem_addr,
    input  logic [word_w-1:0] imem_data,
    output logic [word_w-1:0] dmem_addr,
    output logic [word_w-1:0] dmem_wdata,
    output dsize_t            dmem_size,
    output logic              dmem_we,
    input  logic [word_w-1:0] dmem_rdata
);

    //////////////////////////////
    // stage to stage nets
    //////////////////////////////

    // if/id
    logic [word_w-1:0]    if_pc_next;
    instr_u               if_instr;

    // register file read side
    logic [reg_idx_w-1:0] rs1_idx;
    logic [reg_idx_w-1:0] rs2_idx;
    logic [word_w-1:0]    rs1_value;
    logic [word_w-1:0]    rs2_value;

    // id/ex
    logic [word_w-1:0]    ex_pc_next;
    logic [word_w-1:0]    ex_op_a;
    logic [word_w-1:0]    ex_op_b;
    logic [word_w-1:0]    ex_imm;
    logic [reg_idx_w-1:0] ex_dest;
    alu_op_t              ex_alu_op;
    logic                 ex_use_imm;
    logic                 ex_branch;
    logic                 ex_branch_zero;
    logic                 ex_jump;
    logic                 ex_reg_to_pc;
    logic                 ex_reg_write;
    logic                 ex_mem_to_reg;
    logic                 ex_mem_write;
    logic                 ex_load_sign;
    dsize_t               ex_dsize;

    // ex/mem, leap goes back to fetch
    logic [word_w-1:0]    mem_alu_result;
    logic [word_w-1:0]    mem_store_data;
    logic [reg_idx_w-1:0] mem_dest;
    logic                 mem_reg_write;
    logic                 mem_mem_to_reg;
    logic                 mem_mem_write;
    logic                 mem_load_sign;
    dsize_t               mem_dsize;
    logic                 leap;
    logic [word_w-1:0]    leap_addr;

    // mem/wb into the register file write port
    logic                 wb_we;
    logic [reg_idx_w-1:0] wb_rd;
    logic [word_w-1:0]    wb_value;

    //////////////////////////////
    // stages in pipeline order
    //////////////////////////////

    fetch_unit u_fetch (.*);

    decode_control u_decode (.*);

    register_file u_regs (.*);

    execute_unit u_execute (.*);

    memory_writeback u_mem_wb (.*);

endmodule

/* bench/dlx_checker.sv */
module dlx_checker
    import dlx_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic [word_w-1:0] imem_addr,
    input logic              dmem_we,
    input dsize_t            dmem_size
);

    timeunit 1ns;
    timeprecision 1ps;

    // ex/mem cleared one edge into reset
    we_low_in_reset: assert property (@(posedge clk) !rst_n |=> !dmem_we)
        else $error("dmem_we high during reset");

    // size code 3 is unused
    size_legal: assert property (@(posedge clk) dmem_we |-> (2'(dmem_size) != 2'd3))
        else $error("illegal dmem_size on a store");

    pc_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
        else $error("imem_addr not word aligned");

endmodule

bind dlx_core dlx_checker u_checker (.*);

/* bench/dlx_tb.sv */
module dlx_tb
    import dlx_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int imem_words = 512;
    localparam int dmem_words = 64;
    localparam logic [31:0] data_base = 32'h0000_1000;
    localparam int max_cycles = 6000;

    logic              clk;
    logic              rst_n;
    logic [word_w-1:0] imem_addr;
    logic [word_w-1:0] imem_data;
    logic [word_w-1:0] dmem_addr;
    logic [word_w-1:0] dmem_wdata;
    dsize_t            dmem_size;
    logic              dmem_we;
    logic [word_w-1:0] dmem_rdata;

    // dut side memories and the model's own copies
    logic [31:0] imem [imem_words];
    logic [31:0] dmem [dmem_words];
    logic [31:0] model_mem [dmem_words];
    logic [31:0] model_regs [32];

    // expected fetch trace and store list
    logic [31:0] trace_q [$];
    logic [31:0] st_addr_q [$];
    logic [31:0] st_data_q [$];
    logic [1:0]  st_size_q [$];

    int nblk;

    // combinational memories
    assign imem_data  = imem[imem_addr[10:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    dlx_core DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // every bit of the address feeds the pattern
    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[31:16]};
    endfunction

    // big-endian lane merge where the lowest address is the top lane
    function automatic logic [31:0] merge_store(logic [31:0] old, logic [31:0] addr,
                                                logic [31:0] data, logic [1:0] size);
        logic [31:0] w;
        int lane;
        w = old;
        if (size == 2'd0) begin
            lane = 3 - int'(addr[1:0]);
            w[lane*8 +: 8] = data[7:0];
        end else if (size == 2'd1) begin
            lane = 1 - int'(addr[1]);
            w[lane*16 +: 16] = data[15:0];
        end else begin
            w = data;
        end
        return w;
    endfunction

    function automatic instr_u encode_r(func_t fn, int rd, int rs1, int rs2);
        instr_u w;
        w = '0;
        w.r.opcode = op_alu_r;
        w.r.rs1    = 5'(rs1);
        w.r.rs2    = 5'(rs2);
        w.r.rd     = 5'(rd);
        w.r.func   = fn;
        return w;
    endfunction

    // rd is the data register of a store and rs1 the tested register of a branch
    function automatic instr_u encode_i(opcode_t op, int rd, int rs1, int imm);
        instr_u w;
        w = '0;
        w.i.opcode = op;
        w.i.rs1    = 5'(rs1);
        w.i.rd     = 5'(rd);
        w.i.imm16  = 16'(imm);
        return w;
    endfunction

    function automatic instr_u encode_j(int imm);
        instr_u w;
        w = '0;
        w.i.opcode = op_j;
        w[25:0]    = 26'(imm);
        return w;
    endfunction

    // one instruction plus three nops
    task automatic emit(instr_u w);
        imem[nblk*4] = w;
        for (int s = 1; s < 4; s++) begin
            imem[nblk*4 + s] = '0;
        end
        nblk++;
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // random program
    //////////////////////////////

    task automatic build_program();
        func_t   fns [11] = '{fn_add, fn_sub, fn_and, fn_or, fn_xor, fn_sll, fn_srl,
                              fn_sra, fn_slt, fn_seq, fn_sne};
        opcode_t iops [6] = '{op_addi, op_andi, op_ori, op_xori, op_slli, op_lhi};
        opcode_t lops [5] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw};
        opcode_t sops [3] = '{op_sb, op_sh, op_sw};
        opcode_t op;
        int kind;
        int rd;
        int rs;
        int rt;
        int k;
        int off;
        int tgt;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = '0;
        end
        nblk = 0;
        // r1 holds the data base and r2..r5 start random
        emit(encode_i(op_lhi, 1, 0, 0));
        emit(encode_i(op_ori, 1, 1, int'(data_base)));
        for (int r = 2; r <= 5; r++) begin
            emit(encode_i(op_lhi, r, 0, int'($urandom)));
            emit(encode_i(op_ori, r, r, int'($urandom)));
        end
        while (nblk < 110) begin
            kind = $urandom_range(0, 7);
            // r0 as a destination now and then but never r1 or r10
            rd = $urandom_range(1, 9);
            if (rd == 1) begin
                rd = 0;
            end
            rs  = $urandom_range(0, 9);
            rt  = $urandom_range(0, 9);
            off = $urandom_range(0, 255);
            k   = $urandom_range(0, 2);
            case (kind)
                0, 1: begin
                    emit(encode_r(fns[$urandom_range(0, 10)], rd, rs, rt));
                    emit(encode_i(op_sw, rd, 1, off & ~3));
                end
                2: begin
                    emit(encode_i(iops[$urandom_range(0, 5)], rd, rs, int'($urandom)));
                    emit(encode_i(op_sw, rd, 1, off & ~3));
                end
                3: begin
                    op = lops[$urandom_range(0, 4)];
                    if (op == op_lh || op == op_lhu) begin
                        off = off & ~1;
                    end else if (op == op_lw) begin
                        off = off & ~3;
                    end
                    emit(encode_i(op, rd, 1, off));
                    emit(encode_i(op_sw, rd, 1, int'($urandom_range(0, 63)) * 4));
                end
                4: begin
                    op = sops[$urandom_range(0, 2)];
                    if (op == op_sh) begin
                        off = off & ~1;
                    end else if (op == op_sw) begin
                        off = off & ~3;
                    end
                    emit(encode_i(op, rt, 1, off));
                end
                5: begin
                    // forward only with the offset counted from pc+4
                    tgt = (nblk + 1 + k) * 16;
                    op  = ($urandom_range(0, 1) == 0) ? op_beqz : op_bnez;
                    emit(encode_i(op, 0, rs, tgt - (nblk*16 + 4)));
                end
                6: begin
                    tgt = (nblk + 1 + k) * 16;
                    emit(encode_j(tgt - (nblk*16 + 4)));
                end
                default: begin
                    // r10 gets a target past the jr and the blocks it skips
                    tgt = (nblk + 2 + k) * 16;
                    emit(encode_i(op_ori, 10, 0, tgt));
                    emit(encode_i(op_jr, 0, 10, 0));
                end
            endcase
            // stores that a taken leap jumps over
            if (kind >= 5) begin
                for (int f = 0; f < k; f++) begin
                    emit(encode_i(op_sw, rt, 1, int'($urandom_range(0, 63)) * 4));
                end
            end
        end
        // landing room for the last leaps
        for (int p = 0; p < 3; p++) begin
            emit('0);
        end
        // j to itself
        emit(encode_j(-4));
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    task automatic run_model();
        instr_u      w;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [7:0]  bval;
        logic [15:0] hval;
        logic        wr;
        pc = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int steps = 0; steps < 1000; steps++) begin
            w = imem[pc[10:2]];
            for (int s = 0; s < 4; s++) begin
                trace_q.push_back(pc + 32'(4*s));
            end
            a       = model_regs[w.r.rs1];
            b       = model_regs[w.r.rs2];
            simm    = {{16{w.i.imm16[15]}}, w.i.imm16};
            zimm    = {16'b0, w.i.imm16};
            addr    = a + simm;
            word    = model_mem[addr[7:2]];
            bval    = word[(3 - int'(addr[1:0]))*8 +: 8];
            hval    = word[(1 - int'(addr[1]))*16 +: 16];
            next_pc = pc + 32'd16;
            res     = '0;
            wr      = 1'b1;
            case (w.i.opcode)
                op_alu_r: begin
                    case (w.r.func)
                        fn_add:  res = a + b;
                        fn_sub:  res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_xor:  res = a ^ b;
                        fn_sll:  res = a << b[4:0];
                        fn_srl:  res = a >> b[4:0];
                        fn_sra:  res = $signed(a) >>> b[4:0];
                        fn_slt:  res = {31'b0, $signed(a) < $signed(b)};
                        fn_seq:  res = {31'b0, a == b};
                        fn_sne:  res = {31'b0, a != b};
                        default: wr = 1'b0;
                    endcase
                    if (wr) begin
                        model_regs[w.r.rd] = res;
                    end
                end
                op_addi: model_regs[w.i.rd] = a + simm;
                op_andi: model_regs[w.i.rd] = a & zimm;
                op_ori:  model_regs[w.i.rd] = a | zimm;
                op_xori: model_regs[w.i.rd] = a ^ zimm;
                op_slli: model_regs[w.i.rd] = a << simm[4:0];
                op_lhi:  model_regs[w.i.rd] = {w.i.imm16, 16'b0};
                op_lb:   model_regs[w.i.rd] = {{24{bval[7]}}, bval};
                op_lbu:  model_regs[w.i.rd] = {24'b0, bval};
                op_lh:   model_regs[w.i.rd] = {{16{hval[15]}}, hval};
                op_lhu:  model_regs[w.i.rd] = {16'b0, hval};
                op_lw:   model_regs[w.i.rd] = word;
                op_sb, op_sh, op_sw: begin
                    st_addr_q.push_back(addr);
                    st_data_q.push_back(model_regs[w.i.rd]);
                    if (w.i.opcode == op_sb) begin
                        st_size_q.push_back(2'd0);
                    end else if (w.i.opcode == op_sh) begin
                        st_size_q.push_back(2'd1);
                    end else begin
                        st_size_q.push_back(2'd2);
                    end
                    model_mem[addr[7:2]] = merge_store(word, addr, model_regs[w.i.rd],
                                                       st_size_q[$]);
                end
                op_beqz: if (a == '0) next_pc = pc + 32'd4 + simm;
                op_bnez: if (a != '0) next_pc = pc + 32'd4 + simm;
                op_j:    next_pc = pc + 32'd4 + {{6{w[25]}}, w[25:0]};
                op_jr:   next_pc = a;
                default: wr = 1'b0;
            endcase
            // r0 stays zero
            model_regs[0] = '0;
            // the self loop ends the trace with one more fetch of itself
            if (next_pc == pc) begin
                trace_q.push_back(pc);
                break;
            end
            pc = next_pc;
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int cycles;
        void'($urandom(32'hc0a99a29));
        rst_n = 1'b0;
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i]      = fill_word(data_base + 32'(4*i));
            model_mem[i] = dmem[i];
        end
        build_program();
        run_model();
        repeat (16) @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        // sampled at the falling edge with one fetch per cycle
        while (trace_q.size() > 0 || st_addr_q.size() > 0) begin
            if (cycles >= max_cycles) begin
                $display("Timeout: the final store and self loop were not reached in time");
                $display("Errors found");
                $fatal(1);
            end
            if (trace_q.size() > 0) begin
                check_value("imem_addr", imem_addr, trace_q.pop_front());
            end
            if (dmem_we) begin
                if (st_addr_q.size() == 0) begin
                    $display("A store reached the data memory when none was expected");
                    $display("Errors found");
                    $fatal(1);
                end
                check_value("dmem_addr", dmem_addr, st_addr_q.pop_front());
                check_value("dmem_wdata", dmem_wdata, st_data_q.pop_front());
                check_value("dmem_size", {30'b0, dmem_size}, {30'b0, st_size_q.pop_front()});
                dmem[dmem_addr[7:2]] = merge_store(dmem[dmem_addr[7:2]], dmem_addr,
                                                   dmem_wdata, dmem_size);
            end
            @(negedge clk);
            cycles++;
        end
        $display("No errors");
        $finish;
    end

endmodule

/* list.f */
hdl/dlx_pkg.sv
hdl/fetch_unit.sv
hdl/register_file.sv
hdl/decode_control.sv
hdl/execute_unit.sv
hdl/memory_writeback.sv
hdl/dlx_core.sv
bench/dlx_checker.sv
bench/dlx_tb.sv

/* run.sh */
#!/bin/bash
# build with Verilator, run, then search the log for the pass line
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module dlx_tb -o dlx_sim \
    && ./obj_dir/dlx_sim > sim.log 2>&1 \
    || echo "simulation did not complete" >> sim.log
cat sim.log
grep -qx "No errors" sim.log && exit 0 || exit 1
